// File: project.f
logic/cpu_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/register_bank.sv
logic/data_memory.sv
logic/instruction_memory.sv
logic/program_counter.sv
logic/cpu_top.sv
verification/tb_clock_gen.sv
verification/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - logic/cpu_pkg.sv
      - logic/control_unit.sv
      - logic/alu.sv
      - logic/register_bank.sv
      - logic/data_memory.sv
      - logic/instruction_memory.sv
      - logic/program_counter.sv
      - logic/cpu_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/cpu_tb.sv

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int CYCLE_LIMIT = 2000; // Five short programs plus reset and load time

	logic  clock;
	logic  gen_rst_n;
	logic  test_rst_n;
	logic  rst_n;
	logic  prog_we;
	word_t prog_addr;
	word_t prog_data;
	word_t switches;
	logic  input_valid;
	word_t out_data;
	logic  out_valid;
	logic  halt;
	word_t pc;

	integer seed;
	int     cycle_count;
	int     checks;
	int     errors;
	int     tests_run;
	int     tests_failed;
	int     test_errors_start;
	int     test_checks_start;

	word_t prog[$];
	word_t expected[$];
	word_t observed[$];

	assign rst_n = gen_rst_n & test_rst_n; // Tests re-enter reset for each program

	tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clock_gen (
		.o_clock(clock),
		.o_rst_n(gen_rst_n)
	);

	cpu_top #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) u_dut (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_prog_we(prog_we),
		.i_prog_addr(prog_addr),
		.i_prog_data(prog_data),
		.i_switches(switches),
		.i_input_valid(input_valid),
		.o_out_data(out_data),
		.o_out_valid(out_valid),
		.o_halt(halt),
		.o_pc(pc)
	);

	// Instruction encoders
	function automatic word_t r_type(funct_e fn, logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
		instr_t ins;
		ins = '0;
		ins.opcode = OP_RTYPE;
		ins.rs = rs;
		ins.rt = rt;
		ins.rd = rd;
		ins.func = fn;
		return word_t'(ins);
	endfunction

	function automatic word_t i_type(opcode_e op, logic [4:0] rt, logic [4:0] rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_type(opcode_e op, logic [25:0] target);
		return {op, target};
	endfunction

	function automatic word_t out_instr(logic [4:0] rs);
		return i_type(OP_OUT, 5'd0, rs, 16'd0);
	endfunction

	function automatic word_t halt_instr();
		return j_type(OP_HALT, 26'd0);
	endfunction

	// Expected values from the instruction set rules
	function automatic word_t sext16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t bool_word(logic v);
		return {31'd0, v};
	endfunction

	function automatic word_t quotient(word_t x, word_t y);
		if (y == '0) begin
			return '0; // Zero divisor yields zero
		end
		return $signed(x) / $signed(y);
	endfunction

	function automatic word_t remainder(word_t x, word_t y);
		if (y == '0) begin
			return '0;
		end
		return $signed(x) % $signed(y);
	endfunction

	function automatic logic [15:0] rand16();
		return $random(seed);
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// R-type result into r4, then OUT r4
	task automatic emit_r_out(funct_e fn, logic [4:0] rs, logic [4:0] rt, word_t exp);
		prog.push_back(r_type(fn, 5'd4, rs, rt));
		prog.push_back(out_instr(5'd4));
		expected.push_back(exp);
	endtask

	// Immediate result into r5, then OUT r5
	task automatic emit_i_out(opcode_e op, logic [4:0] rs, logic [15:0] imm, word_t exp);
		prog.push_back(i_type(op, 5'd5, rs, imm));
		prog.push_back(out_instr(5'd5));
		expected.push_back(exp);
	endtask

	task automatic start_test();
		prog.delete();
		expected.delete();
		observed.delete();
		test_errors_start = errors;
		test_checks_start = checks;
	endtask

	task automatic finish_test(string name);
		tests_run++;
		if (errors != test_errors_start) begin
			tests_failed++;
		end
		$display("Test %s: %0d checks, %0d errors", name, checks - test_checks_start,
			errors - test_errors_start);
	endtask

	// Program is written while the core sits in reset
	task automatic load_program();
		@(negedge clock);
		test_rst_n = 1'b0;
		for (int i = 0; i < prog.size(); i++) begin
			prog_we = 1'b1;
			prog_addr = word_t'(i);
			prog_data = prog[i];
			@(negedge clock);
		end
		prog_we = 1'b0;
		check_word("o_pc", pc, '0);
		check_flag("o_out_valid", out_valid, 1'b0);
		test_rst_n = 1'b1;
	endtask

	task automatic collect_until_halt();
		logic done;
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			if (out_valid) begin
				observed.push_back(out_data);
			end
			done = halt;
		end
	endtask

	task automatic compare_outputs();
		int n;
		if (observed.size() != expected.size()) begin
			errors++;
			$display("Output count wrong at %0d ns: saw %0d OUT strobes, expected %0d",
				$time, observed.size(), expected.size());
		end
		n = (observed.size() < expected.size()) ? observed.size() : expected.size();
		for (int i = 0; i < n; i++) begin
			check_word($sformatf("o_out_data[%0d]", i), observed[i], expected[i]);
		end
	endtask

	task automatic run_program();
		load_program();
		collect_until_halt();
		compare_outputs();
	endtask

	task automatic test_arith();
		logic [15:0] a16;
		logic [15:0] b16;
		logic [15:0] c16;
		word_t       a;
		word_t       b;
		word_t       c;
		start_test();
		a16 = rand16();
		b16 = rand16();
		c16 = rand16();
		if (b16 == '0) b16 = 16'd3;
		if (c16 == '0) c16 = 16'd5;
		a = sext16(a16);
		b = sext16(b16);
		c = sext16(c16);
		prog.push_back(i_type(OP_LI, 5'd1, 5'd0, a16));
		prog.push_back(i_type(OP_LI, 5'd2, 5'd0, b16));
		prog.push_back(i_type(OP_LI, 5'd3, 5'd0, 16'd0)); // Zero divisor
		emit_r_out(FN_ADD, 5'd1, 5'd2, a + b);
		emit_r_out(FN_SUB, 5'd1, 5'd2, a - b);
		emit_r_out(FN_MUL, 5'd1, 5'd2, a * b);
		emit_r_out(FN_DIV, 5'd1, 5'd2, quotient(a, b));
		emit_r_out(FN_MOD, 5'd1, 5'd2, remainder(a, b));
		emit_r_out(FN_DIV, 5'd1, 5'd3, quotient(a, '0));
		emit_r_out(FN_MOD, 5'd1, 5'd3, remainder(a, '0));
		emit_i_out(OP_ADDI, 5'd1, c16, a + c);
		emit_i_out(OP_SUBI, 5'd1, c16, a - c);
		emit_i_out(OP_MULI, 5'd1, c16, a * c);
		emit_i_out(OP_DIVI, 5'd1, c16, quotient(a, c));
		emit_i_out(OP_MODI, 5'd1, c16, remainder(a, c));
		emit_i_out(OP_DIVI, 5'd1, 16'd0, quotient(a, '0));
		prog.push_back(halt_instr());
		run_program();
		finish_test("arithmetic");
	endtask

	task automatic test_logic();
		logic [15:0] a16;
		logic [15:0] b16;
		logic [15:0] c16;
		logic [15:0] s16;
		logic [4:0]  sh;
		word_t       a;
		word_t       b;
		word_t       c;
		start_test();
		a16 = rand16();
		b16 = rand16();
		c16 = rand16();
		s16 = rand16(); // Upper bits must be ignored by shifts
		if (a16 == '0) a16 = 16'd1;
		sh = s16[4:0];
		a = sext16(a16);
		b = sext16(b16);
		c = sext16(c16);
		prog.push_back(i_type(OP_LI, 5'd1, 5'd0, a16));
		prog.push_back(i_type(OP_LI, 5'd2, 5'd0, b16));
		prog.push_back(i_type(OP_LI, 5'd6, 5'd0, s16));
		emit_r_out(FN_AND, 5'd1, 5'd2, a & b);
		emit_r_out(FN_OR, 5'd1, 5'd2, a | b);
		emit_r_out(FN_XOR, 5'd1, 5'd2, a ^ b);
		emit_r_out(FN_LAND, 5'd1, 5'd2, bool_word((a != '0) && (b != '0)));
		emit_r_out(FN_LAND, 5'd1, 5'd0, bool_word(1'b0));
		emit_r_out(FN_LOR, 5'd0, 5'd0, bool_word(1'b0));
		emit_r_out(FN_LOR, 5'd1, 5'd0, bool_word(1'b1));
		emit_r_out(FN_SLL, 5'd1, 5'd6, a << sh);
		emit_r_out(FN_SRL, 5'd1, 5'd6, a >> sh);
		emit_r_out(FN_EQ, 5'd1, 5'd2, bool_word(a == b));
		emit_r_out(FN_EQ, 5'd1, 5'd1, bool_word(1'b1));
		emit_r_out(FN_NE, 5'd1, 5'd2, bool_word(a != b));
		emit_r_out(FN_LT, 5'd1, 5'd2, bool_word($signed(a) < $signed(b)));
		emit_r_out(FN_LET, 5'd1, 5'd2, bool_word($signed(a) <= $signed(b)));
		emit_r_out(FN_LET, 5'd1, 5'd1, bool_word(1'b1));
		emit_r_out(FN_GT, 5'd1, 5'd2, bool_word($signed(a) > $signed(b)));
		emit_r_out(FN_GET, 5'd1, 5'd2, bool_word($signed(a) >= $signed(b)));
		emit_r_out(FN_GET, 5'd2, 5'd2, bool_word(1'b1));
		emit_i_out(OP_NOT, 5'd1, 16'd0, ~a);
		emit_i_out(OP_ANDI, 5'd1, c16, a & c);
		emit_i_out(OP_ORI, 5'd1, c16, a | c);
		emit_i_out(OP_XORI, 5'd1, c16, a ^ c);
		emit_i_out(OP_LANDI, 5'd1, c16, bool_word(c != '0));
		emit_i_out(OP_LORI, 5'd0, 16'd0, bool_word(1'b0));
		emit_i_out(OP_SLLI, 5'd1, {11'd0, sh}, a << sh);
		emit_i_out(OP_SRLI, 5'd1, {11'd0, sh}, a >> sh);
		prog.push_back(halt_instr());
		run_program();
		finish_test("logic_shift_compare");
	endtask

	task automatic test_memory();
		logic [15:0] v [4];
		start_test();
		for (int i = 0; i < 4; i++) begin
			v[i] = rand16();
		end
		for (int i = 0; i < 4; i++) begin
			prog.push_back(i_type(OP_LI, 5'(i + 1), 5'd0, v[i]));
		end
		prog.push_back(i_type(OP_LI, 5'd9, 5'd0, 16'd100)); // Base address
		prog.push_back(i_type(OP_SW, 5'd1, 5'd0, 16'd10));
		prog.push_back(i_type(OP_SW, 5'd2, 5'd0, 16'd37));
		prog.push_back(i_type(OP_SW, 5'd3, 5'd9, 16'd5));
		prog.push_back(i_type(OP_SW, 5'd4, 5'd9, 16'hffff)); // Address 99
		prog.push_back(i_type(OP_LW, 5'd10, 5'd0, 16'd10));
		prog.push_back(out_instr(5'd10));
		prog.push_back(i_type(OP_LW, 5'd11, 5'd9, 16'hffc1)); // 100 - 63
		prog.push_back(out_instr(5'd11));
		prog.push_back(i_type(OP_LW, 5'd12, 5'd0, 16'd105));
		prog.push_back(out_instr(5'd12));
		prog.push_back(i_type(OP_LW, 5'd13, 5'd0, 16'd99));
		prog.push_back(out_instr(5'd13));
		for (int i = 0; i < 4; i++) begin
			expected.push_back(sext16(v[i]));
		end
		// Writes to r0 are dropped
		prog.push_back(i_type(OP_LI, 5'd0, 5'd0, 16'h1234));
		prog.push_back(out_instr(5'd0));
		prog.push_back(i_type(OP_ADDI, 5'd0, 5'd1, 16'd1));
		prog.push_back(out_instr(5'd0));
		expected.push_back('0);
		expected.push_back('0);
		prog.push_back(halt_instr());
		run_program();
		finish_test("memory");
	endtask

	task automatic test_control();
		start_test();
		prog.push_back(i_type(OP_LI, 5'd1, 5'd0, 16'd11)); // 0
		prog.push_back(i_type(OP_LI, 5'd2, 5'd0, 16'd22)); // 1
		prog.push_back(j_type(OP_J, 26'd4));               // 2
		prog.push_back(out_instr(5'd2));                   // 3 skipped by j
		prog.push_back(out_instr(5'd1));                   // 4
		prog.push_back(j_type(OP_JAL, 26'd10));            // 5
		prog.push_back(out_instr(5'd2));                   // 6 return point
		prog.push_back(j_type(OP_J, 26'd14));              // 7
		prog.push_back(halt_instr());                      // 8
		prog.push_back(halt_instr());                      // 9
		prog.push_back(out_instr(5'd31));                  // 10 subroutine
		prog.push_back(r_type(FN_JR, 5'd0, 5'd31, 5'd0));  // 11
		prog.push_back(halt_instr());                      // 12
		prog.push_back(halt_instr());                      // 13
		prog.push_back(i_type(OP_LI, 5'd3, 5'd0, 16'd0));  // 14
		prog.push_back(i_type(OP_JF, 5'd0, 5'd3, 16'd18)); // 15 taken
		prog.push_back(out_instr(5'd2));                   // 16 skipped
		prog.push_back(halt_instr());                      // 17
		prog.push_back(i_type(OP_JF, 5'd0, 5'd1, 16'd20)); // 18 falls through
		prog.push_back(out_instr(5'd1));                   // 19
		prog.push_back(halt_instr());                      // 20
		expected.push_back(word_t'(11));
		expected.push_back(word_t'(5 + 1)); // Link holds address after jal
		expected.push_back(word_t'(22));
		expected.push_back(word_t'(11));
		run_program();
		finish_test("control_flow");
	endtask

	task automatic test_input_halt();
		word_t sw_value;
		start_test();
		sw_value = $random(seed);
		prog.push_back(i_type(OP_IN, 5'd5, 5'd0, 16'd0));
		prog.push_back(out_instr(5'd5));
		prog.push_back(halt_instr());
		expected.push_back(sw_value);
		load_program();
		// Core must stall on IN with no input present
		repeat (12) begin
			@(negedge clock);
			check_word("o_pc", pc, '0);
			check_flag("o_out_valid", out_valid, 1'b0);
		end
		switches = sw_value;
		input_valid = 1'b1;
		@(negedge clock);
		input_valid = 1'b0;
		check_word("o_pc", pc, word_t'(1));
		collect_until_halt();
		compare_outputs();
		repeat (20) begin
			@(negedge clock);
			check_flag("o_halt", halt, 1'b1);
			check_word("o_pc", pc, word_t'(2));
		end
		finish_test("input_halt");
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: run went past %0d clock cycles", CYCLE_LIMIT);
		$display("sim failed");
		$finish;
	end

	initial begin
		seed = 32'h948a_c63e;
		test_rst_n = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		switches = '0;
		input_valid = 1'b0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		wait (gen_rst_n === 1'b1);
		test_arith();
		test_logic();
		test_memory();
		test_control();
		test_input_halt();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		@(negedge o_clock); // Release away from the active edge
		o_rst_n = 1'b1;
	end

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic           i_clock,
	input  logic           i_rst_n,
	input  logic           i_prog_we,
	input  cpu_pkg::word_t i_prog_addr,
	input  cpu_pkg::word_t i_prog_data,
	input  cpu_pkg::word_t i_switches,
	input  logic           i_input_valid,
	output cpu_pkg::word_t o_out_data,
	output logic           o_out_valid,
	output logic           o_halt,
	output cpu_pkg::word_t o_pc
);
	import cpu_pkg::*;

	word_t                 pc;
	word_t                 pc_next_seq;
	instr_t                instr;
	ctrl_t                 ctrl;
	word_t                 rs_data;
	word_t                 rt_data;
	logic [15:0]           imm;
	word_t                 imm_sext;
	word_t                 imm_zext;
	word_t                 jump_target;
	word_t                 alu_b;
	word_t                 alu_result;
	word_t                 mem_rdata;
	word_t                 wb_data;
	logic [REG_ADDR_W-1:0] waddr;
	logic                  is_false;
	logic                  mem_we;

	assign imm = get_imm(instr);
	assign imm_sext = {{(XLEN-16){imm[15]}}, imm};
	assign imm_zext = {{(XLEN-16){1'b0}}, imm};
	assign jump_target = {{(XLEN-26){1'b0}}, get_target(instr)};

	program_counter #(.IMEM_DEPTH(IMEM_DEPTH)) u_pc (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_ctrl(ctrl),
		.i_imm(imm_zext),
		.i_target(jump_target),
		.i_reg(rs_data),
		.o_pc(pc),
		.o_pc_next_seq(pc_next_seq)
	);

	instruction_memory #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
		.i_clock(i_clock),
		.i_prog_we(i_prog_we),
		.i_prog_addr(i_prog_addr),
		.i_prog_data(i_prog_data),
		.i_pc(pc),
		.o_instr(instr)
	);

	control_unit u_ctrl (
		.i_instr(instr),
		.i_is_false(is_false),
		.i_input_valid(i_input_valid),
		.o_ctrl(ctrl)
	);

	always_comb begin
		if (ctrl.dest_rt) begin
			waddr = instr.rt;
		end else if (ctrl.is_jal) begin
			waddr = LINK_REG;
		end else begin
			waddr = instr.rd;
		end
	end

	register_bank u_regs (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_we(ctrl.reg_write),
		.i_waddr(waddr),
		.i_wdata(wb_data),
		.i_raddr_a(instr.rs),
		.i_raddr_b(instr.rt),
		.o_rdata_a(rs_data),
		.o_rdata_b(rt_data)
	);

	assign alu_b = ctrl.alu_src_reg ? rt_data : imm_sext; // Shift amount too

	alu u_alu (
		.i_op(ctrl.alu_op),
		.i_a(rs_data),
		.i_b(alu_b),
		.o_result(alu_result)
	);

	assign is_false = (alu_result == '0);

	// No stores while the program is being loaded
	assign mem_we = ctrl.mem_write & i_rst_n;

	data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
		.i_clock(i_clock),
		.i_we(mem_we),
		.i_addr(alu_result),
		.i_wdata(rt_data),
		.o_rdata(mem_rdata)
	);

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:   wb_data = mem_rdata;
			WB_INPUT: wb_data = i_switches;
			WB_LINK:  wb_data = pc_next_seq;
			default:  wb_data = alu_result;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
		end else begin
			o_out_valid <= ctrl.out_write; // One cycle strobe per OUT
		end
	end

	always_ff @(posedge i_clock) begin
		if (ctrl.out_write) begin
			o_out_data <= rs_data;
		end
	end

	assign o_halt = ctrl.halt;
	assign o_pc = pc;

endmodule

// File: logic/program_counter.sv
`timescale 1ns/1ps

module program_counter #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic           i_clock,
	input  logic           i_rst_n,
	input  cpu_pkg::ctrl_t i_ctrl,
	input  cpu_pkg::word_t i_imm,     // jf target
	input  cpu_pkg::word_t i_target,  // j and jal target
	input  cpu_pkg::word_t i_reg,     // jr target
	output cpu_pkg::word_t o_pc,
	output cpu_pkg::word_t o_pc_next_seq
);
	import cpu_pkg::*;

	localparam word_t DEPTH = word_t'(IMEM_DEPTH);

	word_t pc;
	word_t pc_inc;
	word_t pc_target;

	assign pc_inc = (pc + 1) % DEPTH;

	always_comb begin
		case (i_ctrl.pc_src)
			PC_BRANCH: pc_target = i_imm % DEPTH;
			PC_REG:    pc_target = i_reg % DEPTH;
			PC_JUMP:   pc_target = i_target % DEPTH;
			default:   pc_target = pc_inc;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			pc <= '0;
		end else if (!(i_ctrl.halt || i_ctrl.input_wait)) begin
			pc <= pc_target;
		end
	end

	assign o_pc = pc;
	assign o_pc_next_seq = pc_inc; // Link value for jal

endmodule

// File: logic/instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic            i_clock,
	input  logic            i_prog_we,   // Program load strobe
	input  cpu_pkg::word_t  i_prog_addr,
	input  cpu_pkg::word_t  i_prog_data,
	input  cpu_pkg::word_t  i_pc,
	output cpu_pkg::instr_t o_instr
);
	import cpu_pkg::*;

	localparam int AW = $clog2(IMEM_DEPTH);

	word_t mem [IMEM_DEPTH];

	always_ff @(posedge i_clock) begin
		if (i_prog_we) begin
			mem[i_prog_addr[AW-1:0]] <= i_prog_data;
		end
	end

	// Fetch is combinational so the whole instruction fits in one cycle
	assign o_instr = instr_t'(mem[i_pc[AW-1:0]]);

endmodule

// File: logic/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
	parameter int DMEM_DEPTH = 256
) (
	input  logic           i_clock,
	input  logic           i_we,
	input  cpu_pkg::word_t i_addr,  // Word address
	input  cpu_pkg::word_t i_wdata,
	output cpu_pkg::word_t o_rdata
);
	import cpu_pkg::*;

	localparam int AW = $clog2(DMEM_DEPTH);

	word_t            mem [DMEM_DEPTH];
	logic [AW-1:0]    index;

	assign index = i_addr[AW-1:0]; // Upper bits ignored

	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[index] <= i_wdata;
		end
	end

	assign o_rdata = mem[index];

endmodule

// File: logic/register_bank.sv
`timescale 1ns/1ps

module register_bank (
	input  logic                             i_clock,
	input  logic                             i_rst_n,
	input  logic                             i_we,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]   i_waddr,
	input  cpu_pkg::word_t                   i_wdata,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]   i_raddr_a,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]   i_raddr_b,
	output cpu_pkg::word_t                   o_rdata_a,
	output cpu_pkg::word_t                   o_rdata_b
);
	import cpu_pkg::*;

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	word_t regs [NUM_REGS];

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_waddr != '0)) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// r0 is hardwired to zero
	assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_op_e i_op,
	input  cpu_pkg::word_t   i_a,
	input  cpu_pkg::word_t   i_b,
	output cpu_pkg::word_t   o_result
);
	import cpu_pkg::*;

	logic signed [XLEN-1:0] a_s;
	logic signed [XLEN-1:0] b_s;
	logic                   b_zero;
	logic [4:0]             shift;

	assign a_s = i_a;
	assign b_s = i_b;
	assign b_zero = (i_b == '0);
	assign shift = i_b[4:0]; // Amount from low bits only

	always_comb begin
		o_result = '0;
		case (i_op)
			// Arithmetic
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_MUL: o_result = i_a * i_b;
			ALU_DIV: o_result = b_zero ? '0 : word_t'(a_s / b_s);
			ALU_MOD: o_result = b_zero ? '0 : word_t'(a_s % b_s);

			// Bitwise and logical
			ALU_AND:  o_result = i_a & i_b;
			ALU_OR:   o_result = i_a | i_b;
			ALU_XOR:  o_result = i_a ^ i_b;
			ALU_NOT:  o_result = ~i_a;
			ALU_LAND: o_result = word_t'((i_a != '0) && (i_b != '0));
			ALU_LOR:  o_result = word_t'((i_a != '0) || (i_b != '0));

			ALU_SLL: o_result = i_a << shift;
			ALU_SRL: o_result = i_a >> shift; // Logical, zero fill

			// Signed compares yield 0 or 1
			ALU_EQ: o_result = word_t'(a_s == b_s);
			ALU_NE: o_result = word_t'(a_s != b_s);
			ALU_LT: o_result = word_t'(a_s < b_s);
			ALU_LE: o_result = word_t'(a_s <= b_s);
			ALU_GT: o_result = word_t'(a_s > b_s);
			ALU_GE: o_result = word_t'(a_s >= b_s);

			ALU_PASS_B: o_result = i_b;
			ALU_PASS_A: o_result = i_a;
			default:    o_result = '0;
		endcase
	end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  cpu_pkg::instr_t i_instr,
	input  logic            i_is_false,    // Operand of jf was zero
	input  logic            i_input_valid, // Switch value present
	output cpu_pkg::ctrl_t  o_ctrl
);
	import cpu_pkg::*;

	opcode_e op;
	funct_e  fn;
	ctrl_t   ctrl;

	assign op = opcode_e'(i_instr.opcode);
	assign fn = funct_e'(i_instr.func);

	always_comb begin
		ctrl = '0;
		ctrl.pc_src = PC_INC;
		ctrl.wb_sel = WB_ALU;
		ctrl.alu_op = ALU_ADD;
		case (op)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_reg = 1'b1;
				case (fn)
					FN_ADD:  ctrl.alu_op = ALU_ADD;
					FN_SUB:  ctrl.alu_op = ALU_SUB;
					FN_MUL:  ctrl.alu_op = ALU_MUL;
					FN_DIV:  ctrl.alu_op = ALU_DIV;
					FN_MOD:  ctrl.alu_op = ALU_MOD;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_LAND: ctrl.alu_op = ALU_LAND;
					FN_LOR:  ctrl.alu_op = ALU_LOR;
					FN_SLL:  ctrl.alu_op = ALU_SLL;
					FN_SRL:  ctrl.alu_op = ALU_SRL;
					FN_EQ:   ctrl.alu_op = ALU_EQ;
					FN_NE:   ctrl.alu_op = ALU_NE;
					FN_LT:   ctrl.alu_op = ALU_LT;
					FN_LET:  ctrl.alu_op = ALU_LE;
					FN_GT:   ctrl.alu_op = ALU_GT;
					FN_GET:  ctrl.alu_op = ALU_GE;
					FN_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.alu_op = ALU_PASS_A;
						ctrl.pc_src = PC_REG;
					end
					default: ctrl.reg_write = 1'b0; // Unknown func behaves as nop
				endcase
			end
			OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI, OP_ANDI, OP_ORI,
			OP_XORI, OP_NOT, OP_LANDI, OP_LORI, OP_SLLI, OP_SRLI: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_rt = 1'b1;
				case (op)
					OP_ADDI:  ctrl.alu_op = ALU_ADD;
					OP_SUBI:  ctrl.alu_op = ALU_SUB;
					OP_MULI:  ctrl.alu_op = ALU_MUL;
					OP_DIVI:  ctrl.alu_op = ALU_DIV;
					OP_MODI:  ctrl.alu_op = ALU_MOD;
					OP_ANDI:  ctrl.alu_op = ALU_AND;
					OP_ORI:   ctrl.alu_op = ALU_OR;
					OP_XORI:  ctrl.alu_op = ALU_XOR;
					OP_NOT:   ctrl.alu_op = ALU_NOT;
					OP_LANDI: ctrl.alu_op = ALU_LAND;
					OP_LORI:  ctrl.alu_op = ALU_LOR;
					OP_SLLI:  ctrl.alu_op = ALU_SLL;
					default:  ctrl.alu_op = ALU_SRL;
				endcase
			end
			OP_MOV: begin // Copies rs into rt
				ctrl.reg_write = 1'b1;
				ctrl.dest_rt = 1'b1;
				ctrl.alu_src_reg = 1'b1;
				ctrl.alu_op = ALU_PASS_A;
			end
			OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_rt = 1'b1;
				ctrl.wb_sel = WB_MEM;
			end
			OP_LI: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest_rt = 1'b1;
				ctrl.alu_op = ALU_PASS_B;
			end
			OP_LA: begin // rs plus offset
				ctrl.reg_write = 1'b1;
				ctrl.dest_rt = 1'b1;
			end
			OP_SW: ctrl.mem_write = 1'b1;
			OP_IN: begin
				ctrl.dest_rt = 1'b1;
				ctrl.wb_sel = WB_INPUT;
				ctrl.reg_write = i_input_valid;
				ctrl.input_wait = ~i_input_valid; // Stall here until switches are ready
			end
			OP_OUT: begin
				ctrl.out_write = 1'b1;
				ctrl.alu_op = ALU_PASS_A;
			end
			OP_JF: begin
				ctrl.alu_op = ALU_PASS_A;
				ctrl.pc_src = i_is_false ? PC_BRANCH : PC_INC;
			end
			OP_J: ctrl.pc_src = PC_JUMP;
			OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.is_jal = 1'b1;
				ctrl.wb_sel = WB_LINK;
				ctrl.pc_src = PC_JUMP;
			end
			OP_HALT: ctrl.halt = 1'b1;
			default: ctrl.reg_write = 1'b0;
		endcase
	end

	assign o_ctrl = ctrl;

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // jal return address register

	typedef logic [XLEN-1:0] word_t;

	// R-type field layout; I and J types reuse the low bits
	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            func;
	} instr_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,  OP_ADDI = 6'd1,  OP_SUBI = 6'd2,   OP_MULI = 6'd3,
		OP_DIVI  = 6'd4,  OP_MODI = 6'd5,  OP_ANDI = 6'd6,   OP_ORI  = 6'd7,
		OP_XORI  = 6'd8,  OP_NOT  = 6'd9,  OP_LANDI = 6'd10, OP_LORI = 6'd11,
		OP_SLLI  = 6'd12, OP_SRLI = 6'd13, OP_MOV  = 6'd14,  OP_LW   = 6'd15,
		OP_LI    = 6'd16, OP_LA   = 6'd17, OP_SW   = 6'd18,  OP_IN   = 6'd19,
		OP_OUT   = 6'd20, OP_JF   = 6'd21, OP_J    = 6'd22,  OP_JAL  = 6'd23,
		OP_HALT  = 6'd24
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,  FN_SUB = 6'd1,  FN_MUL = 6'd2,   FN_DIV = 6'd3,
		FN_MOD = 6'd4,  FN_AND = 6'd5,  FN_OR  = 6'd6,   FN_XOR = 6'd7,
		FN_LAND = 6'd8, FN_LOR = 6'd9,  FN_SLL = 6'd10,  FN_SRL = 6'd11,
		FN_EQ  = 6'd12, FN_NE  = 6'd13, FN_LT  = 6'd14,  FN_LET = 6'd15,
		FN_GT  = 6'd16, FN_GET = 6'd17, FN_JR  = 6'd18
	} funct_e;

	// Top bit marks the compare group
	typedef enum logic [4:0] {
		ALU_ADD  = 5'b00000, ALU_SUB  = 5'b00001, ALU_MUL = 5'b00010,
		ALU_DIV  = 5'b00011, ALU_MOD  = 5'b00100, ALU_SLL = 5'b00101,
		ALU_SRL  = 5'b00110, ALU_AND  = 5'b01000, ALU_OR  = 5'b01001,
		ALU_XOR  = 5'b01010, ALU_NOT  = 5'b01011, ALU_LAND = 5'b01100,
		ALU_LOR  = 5'b01101, ALU_PASS_B = 5'b01110, ALU_PASS_A = 5'b01111,
		ALU_EQ   = 5'b10000, ALU_NE   = 5'b10001, ALU_LT  = 5'b10010,
		ALU_LE   = 5'b10011, ALU_GT   = 5'b10100, ALU_GE  = 5'b10101
	} alu_op_e;

	typedef enum logic [1:0] {
		PC_INC    = 2'd0,
		PC_BRANCH = 2'd1, // jf target from immediate
		PC_REG    = 2'd2, // jr
		PC_JUMP   = 2'd3  // j and jal
	} pc_src_e;

	typedef enum logic [1:0] {
		WB_ALU   = 2'd0,
		WB_MEM   = 2'd1,
		WB_INPUT = 2'd2,
		WB_LINK  = 2'd3
	} wb_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_write;
		logic    alu_src_reg;  // B from rt, else immediate
		logic    dest_rt;
		logic    is_jal;
		logic    out_write;
		logic    halt;
		logic    input_wait;   // IN stalled on missing input
		pc_src_e pc_src;
		wb_sel_e wb_sel;
		alu_op_e alu_op;
	} ctrl_t;

	function automatic logic [15:0] get_imm(instr_t instr);
		return instr[15:0];
	endfunction

	function automatic logic [25:0] get_target(instr_t instr);
		return instr[25:0];
	endfunction

endpackage
